/* source/pi1_pkg.sv */
`default_nettype none

// definitions shared by every agent on the peripheral interconnect
package pi1_pkg;

	// width of a data word in bits
	localparam int ARCHBITSZ = 32;

	// addresses are word addresses, so the two byte offset bits are dropped
	localparam int ADDRBITSZ = 30;

	// one select bit per byte lane of a data word
	localparam int SELBITSZ = 4;

	// operation codes carried on the op lines
	// the swap writes the new data and hands back the word that was there before
	typedef enum logic [1:0] {
		PI1_NOOP = 2'b00,
		PI1_WROP = 2'b01,
		PI1_RDOP = 2'b10,
		PI1_RWOP = 2'b11
	} pi1_op_t;

	// everything a requester holds steady until it sees rdy
	// 2 + 30 + 32 + 4 bits, 68 in all
	typedef struct packed {
		pi1_op_t op;
		logic [ADDRBITSZ-1:0] addr;
		logic [ARCHBITSZ-1:0] data;
		logic [SELBITSZ-1:0] sel;
	} pi1_req_t;

	// a request with nothing to do, used on idle slave links
	localparam pi1_req_t PI1_REQ_IDLE = '{
		op: PI1_NOOP,
		addr: '0,
		data: '0,
		sel: '0
	};

endpackage

`default_nettype wire

/* source/map_pkg.sv */
`default_nettype none

// address map of the subsystem, all in word addresses
package map_pkg;

	import pi1_pkg::*;

	// the uart sits just below the memory so that the memory starts at byte 0x1000
	localparam logic [ADDRBITSZ-1:0] UART_BASE = 30'h3FE;
	localparam int unsigned UART_MAPSZ = 2;

	// word 0x400 is byte address 0x1000
	localparam logic [ADDRBITSZ-1:0] RAM_BASE = 30'h400;
	localparam int unsigned RAM_MAPSZ = 1024;

	// index of the slave a request is routed to
	typedef logic [1:0] slv_idx_t;

	localparam slv_idx_t SLV_UART = 2'd0;
	localparam slv_idx_t SLV_RAM = 2'd1;

	// catches every address that no slave claims
	localparam slv_idx_t SLV_INVALID = 2'd2;

endpackage

`default_nettype wire

/* source/pi1_if.sv */
`default_nettype none

// one link between the router and a single slave
interface pi1_if ();

	import pi1_pkg::*;

	// operation, word address, write data and byte selects from the router
	pi1_req_t req;

	// read data, only meaningful in the cycle where rdy is high
	logic [ARCHBITSZ-1:0] rdata;

	// one cycle pulse that ends the transaction
	logic rdy;

	// the router side issues requests and waits for rdy
	modport master (
		output req,
		input rdata,
		input rdy
	);

	// the slave side answers them
	modport slave (
		input req,
		output rdata,
		output rdy
	);

endinterface

`default_nettype wire

/* source/pi1_router.sv */
`default_nettype none

// routes the single master port onto one of the slaves
// only one transaction is in flight at a time
module pi1_router (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire pi1_pkg::pi1_req_t req_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0] data_o,
	output logic rdy_o,
	output logic err_o,
	pi1_if.master uart_bus,
	pi1_if.master ram_bus
);

	import pi1_pkg::*;
	import map_pkg::*;

	typedef enum logic {
		IDLE,
		BUSY
	} state_t;

	state_t state_q;
	pi1_req_t req_q;
	slv_idx_t slv_q;
	logic accept;
	logic slv_rdy;
	logic [ARCHBITSZ-1:0] slv_rdata;

	// map a word address to the slave that owns it
	function automatic slv_idx_t decode(input logic [ADDRBITSZ-1:0] addr);
		slv_idx_t idx;
		idx = SLV_INVALID;
		if (addr >= UART_BASE && addr < UART_BASE + UART_MAPSZ) begin
			idx = SLV_UART;
		end else if (addr >= RAM_BASE && addr < RAM_BASE + RAM_MAPSZ) begin
			idx = SLV_RAM;
		end
		return idx;
	endfunction

	// the master still holds its op in the cycle where rdy_o is high,
	// so nothing new is taken until that cycle is over
	assign accept = (state_q == IDLE) && !rdy_o && (req_i.op != PI1_NOOP);

	// response of the selected slave
	// the invalid device is always ready and reads as zero
	always_comb begin
		case (slv_q)
			SLV_UART: begin
				slv_rdy = uart_bus.rdy;
				slv_rdata = uart_bus.rdata;
			end
			SLV_RAM: begin
				slv_rdy = ram_bus.rdy;
				slv_rdata = ram_bus.rdata;
			end
			default: begin
				slv_rdy = 1'b1;
				slv_rdata = '0;
			end
		endcase
	end

	// only the selected link sees the latched request, the other one idles
	always_comb begin
		uart_bus.req = PI1_REQ_IDLE;
		ram_bus.req = PI1_REQ_IDLE;
		if (state_q == BUSY && slv_q == SLV_UART) begin
			uart_bus.req = req_q;
		end
		if (state_q == BUSY && slv_q == SLV_RAM) begin
			ram_bus.req = req_q;
		end
	end

	// the FSM leaves BUSY on the edge where the slave's rdy is seen,
	// which also drops the slave op to NOOP for the next cycle
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			state_q <= IDLE;
			rdy_o <= 1'b0;
			err_o <= 1'b0;
		end else begin
			rdy_o <= 1'b0;
			err_o <= 1'b0;
			case (state_q)
				IDLE: begin
					if (accept) begin
						state_q <= BUSY;
					end
				end
				BUSY: begin
					if (slv_rdy) begin
						state_q <= IDLE;
						rdy_o <= 1'b1;
						err_o <= (slv_q == SLV_INVALID);
					end
				end
				default: state_q <= IDLE;
			endcase
		end
	end

	// latched request, decoded index and registered read data
	always_ff @(posedge clk_i) begin
		if (accept) begin
			req_q <= req_i;
			slv_q <= decode(req_i.addr);
		end
		if (state_q == BUSY && slv_rdy) begin
			data_o <= slv_rdata;
		end
	end

	// the two slave links must never be active together
	a_one_slave: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		!(uart_bus.req.op != PI1_NOOP && ram_bus.req.op != PI1_NOOP));

	// each transaction ends with exactly one rdy pulse on the master port
	a_rdy_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		rdy_o |=> !rdy_o);

endmodule

`default_nettype wire

/* source/pi1_uart.sv */
`default_nettype none

// transmit only uart
// word 0 takes bytes to send, word 1 reads back the status
module pi1_uart #(
	parameter int BUFSZ = 2,
	parameter int CLKDIV = 4
) (
	input wire logic clk_i,
	input wire logic rst_n_i,
	pi1_if.slave bus,
	output logic tx_o
);

	import pi1_pkg::*;
	import map_pkg::*;

	localparam int PTRW = (BUFSZ > 1) ? $clog2(BUFSZ) : 1;
	localparam int CNTW = $clog2(BUFSZ + 1);
	localparam int DIVW = (CLKDIV > 1) ? $clog2(CLKDIV) : 1;

	logic [7:0] fifo_q [BUFSZ];
	logic [PTRW-1:0] wr_ptr_q;
	logic [PTRW-1:0] rd_ptr_q;
	logic [CNTW-1:0] count_q;
	logic [ADDRBITSZ-1:0] offset;
	logic req_live;
	logic is_write;
	logic is_push;
	logic stall;
	logic push;
	logic pop;
	logic full;
	logic tx_idle;
	logic [7:0] free_slots;
	logic [ARCHBITSZ-1:0] status;
	logic [9:0] shift_q;
	logic [3:0] bit_cnt_q;
	logic [DIVW-1:0] div_q;
	logic busy_q;

	// wrap a FIFO pointer at BUFSZ, which need not be a power of two
	function automatic logic [PTRW-1:0] next_ptr(input logic [PTRW-1:0] ptr);
		logic [PTRW-1:0] nxt;
		nxt = (ptr == PTRW'(BUFSZ - 1)) ? '0 : ptr + 1'b1;
		return nxt;
	endfunction

	assign offset = bus.req.addr - UART_BASE;

	// the op is still held in the cycle where rdy is high, so ignore it there
	assign req_live = (bus.req.op != PI1_NOOP) && !bus.rdy;
	assign is_write = (bus.req.op == PI1_WROP) || (bus.req.op == PI1_RWOP);
	assign is_push = req_live && !offset[0] && is_write && bus.req.sel[0];

	// a push into a full FIFO waits here, which back-pressures the master
	assign stall = is_push && full;
	assign push = is_push && !full;
	assign pop = !busy_q && (count_q != '0);

	assign full = (count_q == CNTW'(BUFSZ));
	assign tx_idle = (count_q == '0) && !busy_q;
	assign free_slots = 8'(BUFSZ - count_q);
	assign status = {16'h0000, free_slots, 6'b000000, tx_idle, full};

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			bus.rdy <= 1'b0;
		end else begin
			bus.rdy <= req_live && !stall;
		end
	end

	// only reads and swaps of word 1 return something other than zero
	always_ff @(posedge clk_i) begin
		if (req_live && !stall) begin
			if (offset[0] && bus.req.op inside {PI1_RDOP, PI1_RWOP}) begin
				bus.rdata <= status;
			end else begin
				bus.rdata <= '0;
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (push) begin
			fifo_q[wr_ptr_q] <= bus.req.data[7:0];
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			if (push) begin
				wr_ptr_q <= next_ptr(wr_ptr_q);
			end
			if (pop) begin
				rd_ptr_q <= next_ptr(rd_ptr_q);
			end
			case ({push, pop})
				2'b10: count_q <= count_q + 1'b1;
				2'b01: count_q <= count_q - 1'b1;
				default: count_q <= count_q;
			endcase
		end
	end

	// bit timing of the serializer, ten bits of CLKDIV cycles each
	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			busy_q <= 1'b0;
			bit_cnt_q <= '0;
			div_q <= '0;
		end else if (pop) begin
			busy_q <= 1'b1;
			bit_cnt_q <= '0;
			div_q <= '0;
		end else if (busy_q) begin
			if (div_q == DIVW'(CLKDIV - 1)) begin
				div_q <= '0;
				bit_cnt_q <= bit_cnt_q + 1'b1;
				// the stop bit is the tenth and last one
				if (bit_cnt_q == 4'd9) begin
					busy_q <= 1'b0;
				end
			end else begin
				div_q <= div_q + 1'b1;
			end
		end
	end

	// frame is start bit, data lsb first, then stop bit, sent from bit 0 upward
	always_ff @(posedge clk_i) begin
		if (pop) begin
			shift_q <= {1'b1, fifo_q[rd_ptr_q], 1'b0};
		end else if (busy_q && div_q == DIVW'(CLKDIV - 1)) begin
			shift_q <= {1'b1, shift_q[9:1]};
		end
	end

	// line idles high between frames
	assign tx_o = busy_q ? shift_q[0] : 1'b1;

	a_fifo_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		count_q <= CNTW'(BUFSZ));

endmodule

`default_nettype wire

/* source/pi1_smem.sv */
`default_nettype none

// word memory slave with byte selects and a fixed extra response delay
module pi1_smem #(
	parameter int SIZE = 1024,
	parameter int DELAY = 0
) (
	input wire logic clk_i,
	input wire logic rst_n_i,
	pi1_if.slave bus
);

	import pi1_pkg::*;
	import map_pkg::*;

	localparam int AW = (SIZE > 1) ? $clog2(SIZE) : 1;
	localparam int CW = (DELAY > 0) ? $clog2(DELAY + 1) : 1;

	logic [ARCHBITSZ-1:0] mem_q [SIZE];
	logic [ADDRBITSZ-1:0] offset;
	logic [AW-1:0] idx;
	logic new_op;
	logic wait_q;
	logic [CW-1:0] cnt_q;
	logic fire;
	logic wr_en;

	// word index relative to the base of the memory window
	assign offset = bus.req.addr - RAM_BASE;
	assign idx = offset[AW-1:0];

	// a held op is new only when no countdown runs and rdy is not showing
	assign new_op = (bus.req.op != PI1_NOOP) && !wait_q && !bus.rdy;

	// the access itself happens on the edge before rdy goes high
	assign fire = (DELAY == 0) ? new_op : (wait_q && cnt_q == CW'(1));
	assign wr_en = fire && (bus.req.op == PI1_WROP || bus.req.op == PI1_RWOP);

	always_ff @(posedge clk_i) begin
		if (!rst_n_i) begin
			wait_q <= 1'b0;
			cnt_q <= '0;
			bus.rdy <= 1'b0;
		end else begin
			bus.rdy <= fire;
			if (fire) begin
				wait_q <= 1'b0;
			end else if (new_op) begin
				// start counting down the extra cycles
				wait_q <= 1'b1;
				cnt_q <= CW'(DELAY);
			end else if (wait_q) begin
				cnt_q <= cnt_q - 1'b1;
			end
		end
	end

	// rdata always takes the word as it was before this edge,
	// so a swap returns the old contents while the new bytes go in
	always_ff @(posedge clk_i) begin
		if (fire) begin
			bus.rdata <= mem_q[idx];
		end
		for (int i = 0; i < SELBITSZ; i++) begin
			if (wr_en && bus.req.sel[i]) begin
				mem_q[idx][8*i +: 8] <= bus.req.data[8*i +: 8];
			end
		end
	end

	// the router only hands over addresses inside the window this memory backs
	a_in_range: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		(bus.req.op != PI1_NOOP) |-> (offset < SIZE));

endmodule

`default_nettype wire

/* source/pi1_soc.sv */
`default_nettype none

// top level of the subsystem
// one master port reaches the uart, the memory and the invalid device
module pi1_soc #(
	parameter int BUFSZ = 2,
	parameter int CLKDIV = 4,
	parameter int SIZE = map_pkg::RAM_MAPSZ,
	parameter int DELAY = 0
) (
	input wire logic clk_i,
	input wire logic rst_n_i,
	input wire pi1_pkg::pi1_op_t pi1_op_i,
	input wire logic [pi1_pkg::ADDRBITSZ-1:0] pi1_addr_i,
	input wire logic [pi1_pkg::ARCHBITSZ-1:0] pi1_data_i,
	input wire logic [pi1_pkg::SELBITSZ-1:0] pi1_sel_i,
	output logic [pi1_pkg::ARCHBITSZ-1:0] pi1_data_o,
	output logic pi1_rdy_o,
	output logic pi1_err_o,
	output logic uart_tx_o
);

	import pi1_pkg::*;

	// master request gathered into one bundle for the router
	pi1_req_t m_req;

	assign m_req = '{
		op: pi1_op_i,
		addr: pi1_addr_i,
		data: pi1_data_i,
		sel: pi1_sel_i
	};

	// one link per real slave, the invalid device lives inside the router
	pi1_if uart_bus ();
	pi1_if ram_bus ();

	pi1_router router (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.req_i (m_req),
		.data_o (pi1_data_o),
		.rdy_o (pi1_rdy_o),
		.err_o (pi1_err_o),
		.uart_bus (uart_bus.master),
		.ram_bus (ram_bus.master)
	);

	pi1_uart #(
		.BUFSZ (BUFSZ),
		.CLKDIV (CLKDIV)
	) uart (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.bus (uart_bus.slave),
		.tx_o (uart_tx_o)
	);

	// memory window starts at byte address 0x1000
	pi1_smem #(
		.SIZE (SIZE),
		.DELAY (DELAY)
	) smem (
		.clk_i (clk_i),
		.rst_n_i (rst_n_i),
		.bus (ram_bus.slave)
	);

endmodule

`default_nettype wire

/* bench/tb_tasks.svh */
// one bus transaction, inputs change on the falling edge and the
// response is taken on the falling edge where pi1_rdy_o is seen high
task automatic run_transfer(input pi1_op_t op, input logic [ADDRBITSZ-1:0] addr,
		input logic [ARCHBITSZ-1:0] wdata, input logic [SELBITSZ-1:0] sel,
		output logic [ARCHBITSZ-1:0] rdata, output logic err);
	int cnt;
	logic seen;
	@(negedge clk);
	m_op = op;
	m_addr = addr;
	m_wdata = wdata;
	m_sel = sel;
	cnt = 0;
	seen = 1'b0;
	while (!seen && cnt < TIMEOUT) begin
		@(negedge clk);
		cnt++;
		seen = m_rdy;
	end
	rdata = m_rdata;
	err = m_err;
	last_wait = cnt;
	// op stays NOOP for at least the next rising edge
	m_op = PI1_NOOP;
	if (!seen) begin
		$display("request to word %h got no pi1_rdy_o within %0d cycles", addr, TIMEOUT);
		errors++;
	end
endtask

task automatic bus_write(input logic [ADDRBITSZ-1:0] addr, input logic [ARCHBITSZ-1:0] data,
		input logic [SELBITSZ-1:0] sel);
	logic [ARCHBITSZ-1:0] rdata;
	logic err;
	run_transfer(PI1_WROP, addr, data, sel, rdata, err);
	if (err !== 1'b0) begin
		$display("MISMATCH pi1_err_o on write to %h: got %h, expected 0", addr, err);
		errors++;
	end
endtask

task automatic bus_read(input logic [ADDRBITSZ-1:0] addr, output logic [ARCHBITSZ-1:0] data);
	logic err;
	run_transfer(PI1_RDOP, addr, '0, 4'hf, data, err);
	if (err !== 1'b0) begin
		$display("MISMATCH pi1_err_o on read of %h: got %h, expected 0", addr, err);
		errors++;
	end
endtask

// one line per finished test
task automatic finish_test(input string name, input int errs_at_start);
	tests++;
	$display("%s finished with %0d new errors", name, errors - errs_at_start);
endtask

task automatic check_reset_state();
	int start;
	logic [ARCHBITSZ-1:0] status;
	start = errors;
	if (m_rdy !== 1'b0 || m_err !== 1'b0) begin
		$display("MISMATCH pi1_rdy_o/pi1_err_o after reset: got %h/%h, expected 0/0",
			m_rdy, m_err);
		errors++;
	end
	if (tx !== 1'b1) begin
		$display("MISMATCH uart_tx_o after reset: got %h, expected 1", tx);
		errors++;
	end
	// free slots in bits 15:8, idle in bit 1, full in bit 0
	bus_read(UART_BASE + 1'b1, status);
	if (status[15:0] !== {8'(BUFSZ), 8'h02}) begin
		$display("MISMATCH pi1_data_o uart status: got %h, expected %h", status[15:0],
			{8'(BUFSZ), 8'h02});
		errors++;
	end
	finish_test("check_reset_state", start);
endtask

task automatic mem_round_trip();
	int start;
	logic [9:0] offs [8];
	logic [ARCHBITSZ-1:0] data;
	start = errors;
	for (int i = 0; i < 8; i++) begin
		offs[i] = 10'(rand_bits(10));
		data = rand_bits(32);
		bus_write(RAM_BASE + ADDRBITSZ'(offs[i]), data, 4'hf);
		mem_model[offs[i]] = data;
	end
	for (int i = 0; i < 8; i++) begin
		bus_read(RAM_BASE + ADDRBITSZ'(offs[i]), data);
		if (data !== mem_model[offs[i]]) begin
			$display("MISMATCH pi1_data_o at ram word %h: got %h, expected %h",
				offs[i], data, mem_model[offs[i]]);
			errors++;
		end
	end
	finish_test("mem_round_trip", start);
endtask

task automatic byte_select_writes();
	int start;
	logic [9:0] off;
	logic [3:0] sel;
	logic [ARCHBITSZ-1:0] data;
	start = errors;
	for (int i = 0; i < 6; i++) begin
		off = 10'(rand_bits(10));
		data = rand_bits(32);
		bus_write(RAM_BASE + ADDRBITSZ'(off), data, 4'hf);
		mem_model[off] = data;
		sel = 4'(rand_bits(4));
		data = rand_bits(32);
		bus_write(RAM_BASE + ADDRBITSZ'(off), data, sel);
		mem_model[off] = merge_bytes(mem_model[off], data, sel);
		bus_read(RAM_BASE + ADDRBITSZ'(off), data);
		if (data !== mem_model[off]) begin
			$display("MISMATCH pi1_data_o at ram word %h sel %h: got %h, expected %h",
				off, sel, data, mem_model[off]);
			errors++;
		end
	end
	finish_test("byte_select_writes", start);
endtask

task automatic swap_returns_old();
	int start;
	logic [9:0] off;
	logic [3:0] sel;
	logic [ARCHBITSZ-1:0] data;
	logic [ARCHBITSZ-1:0] rdata;
	logic err;
	start = errors;
	for (int i = 0; i < 4; i++) begin
		off = 10'(rand_bits(10));
		data = rand_bits(32);
		bus_write(RAM_BASE + ADDRBITSZ'(off), data, 4'hf);
		mem_model[off] = data;
		sel = 4'(rand_bits(4));
		data = rand_bits(32);
		run_transfer(PI1_RWOP, RAM_BASE + ADDRBITSZ'(off), data, sel, rdata, err);
		if (rdata !== mem_model[off] || err !== 1'b0) begin
			$display("MISMATCH pi1_data_o/pi1_err_o on swap at %h: got %h/%h, expected %h/0",
				off, rdata, err, mem_model[off]);
			errors++;
		end
		mem_model[off] = merge_bytes(mem_model[off], data, sel);
		bus_read(RAM_BASE + ADDRBITSZ'(off), rdata);
		if (rdata !== mem_model[off]) begin
			$display("MISMATCH pi1_data_o after swap at %h: got %h, expected %h",
				off, rdata, mem_model[off]);
			errors++;
		end
	end
	finish_test("swap_returns_old", start);
endtask

task automatic invalid_access();
	int start;
	logic [ADDRBITSZ-1:0] addr;
	logic [ARCHBITSZ-1:0] rdata;
	logic err;
	start = errors;
	for (int i = 0; i < 6; i++) begin
		// even rounds go below the uart, odd rounds above the memory
		if (i % 2 == 0) begin
			addr = ADDRBITSZ'(rand_bits(9));
		end else begin
			addr = RAM_BASE + ADDRBITSZ'(RAM_MAPSZ) + ADDRBITSZ'(rand_bits(16));
		end
		run_transfer((i < 3) ? PI1_RDOP : PI1_WROP, addr, rand_bits(32), 4'hf, rdata, err);
		if (rdata !== '0 || err !== 1'b1) begin
			$display("MISMATCH pi1_data_o/pi1_err_o at unmapped %h: got %h/%h, expected 0/1",
				addr, rdata, err);
			errors++;
		end
	end
	finish_test("invalid_access", start);
endtask

task automatic uart_transmit();
	int start;
	int max_wait;
	int cnt;
	logic [7:0] sent [$];
	logic [7:0] b;
	logic [ARCHBITSZ-1:0] status;
	start = errors;
	max_wait = 0;
	rx_q.delete();
	// more bytes than the FIFO holds, so some writes must wait
	for (int i = 0; i < BUFSZ + 3; i++) begin
		b = 8'(rand_bits(8));
		sent.push_back(b);
		bus_write(UART_BASE, {24'h000000, b}, 4'b0001);
		if (last_wait > max_wait) begin
			max_wait = last_wait;
		end
	end
	if (max_wait <= 2 * CLKDIV) begin
		$display("no uart write was held back by a full FIFO, longest took %0d cycles",
			max_wait);
		errors++;
	end
	cnt = 0;
	while (rx_q.size() < sent.size() && cnt < TIMEOUT) begin
		@(negedge clk);
		cnt++;
	end
	if (rx_q.size() != sent.size()) begin
		$display("serial monitor received %0d bytes, expected %0d", rx_q.size(), sent.size());
		errors++;
	end
	for (int i = 0; i < sent.size() && i < rx_q.size(); i++) begin
		if (rx_q[i] !== sent[i]) begin
			$display("MISMATCH uart_tx_o byte %0d: got %h, expected %h", i, rx_q[i], sent[i]);
			errors++;
		end
	end
	// the last stop bit may still be on the line, so poll for idle
	cnt = 0;
	status = '0;
	while (!status[1] && cnt < 20) begin
		bus_read(UART_BASE + 1'b1, status);
		cnt++;
	end
	if (status[15:0] !== {8'(BUFSZ), 8'h02}) begin
		$display("MISMATCH pi1_data_o uart status after sending: got %h, expected %h",
			status[15:0], {8'(BUFSZ), 8'h02});
		errors++;
	end
	finish_test("uart_transmit", start);
endtask

/* bench/tb_pi1_soc.sv */
`default_nettype none

// testbench for the peripheral subsystem
// the bench is the only bus master and listens on the serial line
module tb_pi1_soc;

	import pi1_pkg::*;
	import map_pkg::*;

	localparam int BUFSZ = 2;
	localparam int CLKDIV = 4;
	localparam int DELAY = 2;

	// longest wait for any single handshake or event, in clock cycles
	localparam int TIMEOUT = 400;

	logic clk;
	logic rst_n;
	pi1_op_t m_op;
	logic [ADDRBITSZ-1:0] m_addr;
	logic [ARCHBITSZ-1:0] m_wdata;
	logic [SELBITSZ-1:0] m_sel;
	logic [ARCHBITSZ-1:0] m_rdata;
	logic m_rdy;
	logic m_err;
	logic tx;

	int errors;
	int tests;

	// cycles from request to pi1_rdy_o of the most recent transfer
	int last_wait;

	logic [31:0] lfsr_q;

	// expected contents of the memory slave, indexed by word offset
	logic [ARCHBITSZ-1:0] mem_model [RAM_MAPSZ];

	// bytes recovered from the serial line, oldest first
	logic [7:0] rx_q [$];
	logic [7:0] rx_byte;

	always #20 clk = ~clk;

	pi1_soc #(
		.BUFSZ (BUFSZ),
		.CLKDIV (CLKDIV),
		.SIZE (RAM_MAPSZ),
		.DELAY (DELAY)
	) DUT (
		.clk_i (clk),
		.rst_n_i (rst_n),
		.pi1_op_i (m_op),
		.pi1_addr_i (m_addr),
		.pi1_data_i (m_wdata),
		.pi1_sel_i (m_sel),
		.pi1_data_o (m_rdata),
		.pi1_rdy_o (m_rdy),
		.pi1_err_o (m_err),
		.uart_tx_o (tx)
	);

	// 32 bit fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// gather n random bits, one LFSR step for each of them
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[30:0], lfsr_q[0]};
		end
		return v;
	endfunction

	// a write with byte selects only replaces the selected lanes
	function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
			input logic [31:0] new_w, input logic [3:0] sel);
		logic [31:0] w;
		w = old_w;
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) begin
				w[8*i +: 8] = new_w[8*i +: 8];
			end
		end
		return w;
	endfunction

	// serial receiver, samples every bit in its middle on the falling edge
	// a frame is a low start bit, eight data bits lsb first and a high stop bit
	always begin
		@(negedge clk);
		if (rst_n === 1'b1 && tx === 1'b0) begin
			repeat (CLKDIV / 2) @(negedge clk);
			if (tx !== 1'b0) begin
				$display("start bit on uart_tx_o did not last to its middle");
				errors++;
			end else begin
				for (int i = 0; i < 8; i++) begin
					repeat (CLKDIV) @(negedge clk);
					rx_byte[i] = tx;
				end
				repeat (CLKDIV) @(negedge clk);
				if (tx !== 1'b1) begin
					$display("stop bit on uart_tx_o was low after byte %h", rx_byte);
					errors++;
				end
				rx_q.push_back(rx_byte);
			end
		end
	end

	`include "tb_tasks.svh"

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		m_op = PI1_NOOP;
		m_addr = '0;
		m_wdata = '0;
		m_sel = '0;
		errors = 0;
		tests = 0;
		last_wait = 0;
		lfsr_q = 32'hd096;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		check_reset_state();
		mem_round_trip();
		byte_select_writes();
		swap_returns_old();
		invalid_access();
		uart_transmit();
		$display("tests run %0d, errors %0d", tests, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+bench
source/pi1_pkg.sv
source/map_pkg.sv
source/pi1_if.sv
source/pi1_router.sv
source/pi1_uart.sv
source/pi1_smem.sv
source/pi1_soc.sv
bench/tb_pi1_soc.sv

/* run.sh */
#!/usr/bin/env bash
# build the testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_pi1_soc -f files.f -o sim_tb

sim_out=$(./obj_dir/sim_tb)
echo "$sim_out"

if grep -qx "NO ERRORS" <<< "$sim_out"; then
	exit 0
fi
exit 1
